// File: design/bfp_sample_pkg.sv
package bfp_sample_pkg;

    // --------------------
    // Default datapath widths
    // --------------------
    localparam int IW_MAX = 24;
    localparam int OW_MAX = 12;

    // Enough bits for a shift of up to IW_MAX - OW_MAX
    localparam int SHIFT_W = 4;

    // --------------------
    // Sample types
    // --------------------

    // One re or im part at the receiver input
    typedef logic signed [IW_MAX-1:0] sample_t;

    // One re or im part after compression
    typedef logic signed [OW_MAX-1:0] mant_t;

    // OR of magnitude patterns, unsigned
    typedef logic [IW_MAX-1:0] peak_t;

    // Right-shift count for one symbol
    typedef logic [SHIFT_W-1:0] shift_t;

endpackage

// File: design/bfp_header_pkg.sv
package bfp_header_pkg;

    // Raw 64-bit symbol info word
    typedef logic [63:0] info_t;

    // --------------------
    // Header fields
    // --------------------
    typedef logic [3:0] pkg_type_t;
    typedef logic       cell_idx_t;
    typedef logic [6:0] slot_idx_t;
    typedef logic [3:0] symb_idx_t;

    // Low bit of each field inside info_t
    localparam int PKG_TYPE_LSB = 36;
    localparam int CELL_IDX_BIT = 19;
    localparam int SLOT_IDX_LSB = 12;
    localparam int SYMB_IDX_LSB = 8;

    // --------------------
    // Side-band words
    // --------------------

    // Per-channel AGC setting
    typedef logic [7:0] agc_t;

    // Beam power entry and its read index
    typedef logic [31:0] beam_pwr_t;
    typedef logic [3:0]  rbg_idx_t;

endpackage

// File: design/block_peak_search.sv
`timescale 1ns/1ns

module block_peak_search
    import bfp_sample_pkg::*;
#(
    parameter int NUM_CH = 4,
    parameter int IW     = IW_MAX
) (
    input  logic                     clk,
    input  logic                     i_reset,
    input  logic                     i_sop,
    input  logic                     i_eop,
    input  logic                     i_vld,
    input  sample_t [NUM_CH-1:0]     i_din_re,
    input  sample_t [NUM_CH-1:0]     i_din_im,
    output peak_t   [NUM_CH-1:0]     o_peak,
    output logic                     o_peak_vld
);

    peak_t [NUM_CH-1:0] acc;
    peak_t [NUM_CH-1:0] acc_next;

    // Absolute value; the most negative input keeps its own pattern
    function automatic peak_t magnitude(input sample_t s);
        return s[IW-1] ? peak_t'(-s) : peak_t'(s);
    endfunction

    // Running OR per channel, restarted by sop
    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            acc_next[c] = (i_sop ? '0 : acc[c])
                        | magnitude(i_din_re[c])
                        | magnitude(i_din_im[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            acc <= acc_next;
        end
        // Last sample of the symbol included in the result
        if (i_vld && i_eop) begin
            o_peak <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_peak_vld <= 1'b0;
        end else begin
            o_peak_vld <= i_vld & i_eop;
        end
    end

endmodule

// File: design/exponent_select.sv
`timescale 1ns/1ns

module exponent_select
    import bfp_sample_pkg::*;
#(
    parameter int NUM_CH = 4,
    parameter int IW     = IW_MAX,
    parameter int OW     = OW_MAX
) (
    input  logic                 clk,
    input  logic                 i_reset,
    input  peak_t [NUM_CH-1:0]   i_peak,
    input  logic                 i_peak_vld,
    output shift_t               o_shift,
    output logic                 o_shift_vld
);

    // Channels split into two groups for the first OR stage
    localparam int HALF = (NUM_CH + 1) / 2;

    peak_t  or_lo;
    peak_t  or_hi;
    peak_t  lo_q;
    peak_t  hi_q;
    peak_t  merged_q;
    logic   vld_d1;
    logic   vld_d2;
    shift_t shift_next;

    // --------------------
    // OR tree
    // --------------------
    always_comb begin
        or_lo = '0;
        or_hi = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (c < HALF) begin
                or_lo = or_lo | i_peak[c];
            end else begin
                or_hi = or_hi | i_peak[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        lo_q     <= or_lo;
        hi_q     <= or_hi;
        merged_q <= lo_q | hi_q;
    end

    // --------------------
    // Leading-one encoder
    // --------------------

    // Smallest shift leaving the peak below 2**(OW-1); saturates at IW-OW
    always_comb begin
        shift_next = shift_t'(IW - OW);
        for (int s = IW - OW; s >= 0; s--) begin
            if ((merged_q >> (s + OW - 1)) == '0) begin
                shift_next = shift_t'(s);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            vld_d1      <= 1'b0;
            vld_d2      <= 1'b0;
            o_shift_vld <= 1'b0;
            o_shift     <= '0;
        end else begin
            vld_d1      <= i_peak_vld;
            vld_d2      <= vld_d1;
            o_shift_vld <= vld_d2;
            // Held until the next symbol's result
            if (vld_d2) begin
                o_shift <= shift_next;
            end
        end
    end

endmodule

// File: design/symbol_delay_line.sv
`timescale 1ns/1ns

module symbol_delay_line
    import bfp_sample_pkg::*;
    import bfp_header_pkg::*;
#(
    parameter int NUM_CH = 4,
    parameter int IW     = IW_MAX,
    parameter int DEPTH  = 19
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_sel,
    input  logic                          i_sop,
    input  logic                          i_eop,
    input  logic                          i_vld,
    input  logic [NUM_CH-1:0][IW-1:0]     i_din_re,
    input  logic [NUM_CH-1:0][IW-1:0]     i_din_im,
    input  pkg_type_t                     i_pkg_type,
    input  cell_idx_t                     i_cell_idx,
    input  slot_idx_t                     i_slot_idx,
    input  symb_idx_t                     i_symb_idx,
    input  agc_t [NUM_CH-1:0]             i_agc,
    output logic                          o_sel,
    output logic                          o_sop,
    output logic                          o_eop,
    output logic                          o_vld,
    output logic [NUM_CH-1:0][IW-1:0]     o_din_re,
    output logic [NUM_CH-1:0][IW-1:0]     o_din_im,
    output pkg_type_t                     o_pkg_type,
    output cell_idx_t                     o_cell_idx,
    output slot_idx_t                     o_slot_idx,
    output symb_idx_t                     o_symb_idx,
    output agc_t [NUM_CH-1:0]             o_agc
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int HDR_W  = $bits(pkg_type_t) + $bits(cell_idx_t)
                          + $bits(slot_idx_t) + $bits(symb_idx_t);
    localparam int DATA_W = 2 * NUM_CH * IW + HDR_W + NUM_CH * $bits(agc_t);

    logic [PTR_W-1:0]  ptr;
    logic [3:0]        strb_mem [DEPTH];
    logic [DATA_W-1:0] data_mem [DEPTH];
    logic [3:0]        strb_q;
    logic [DATA_W-1:0] data_q;
    logic [DATA_W-1:0] data_in;

    assign data_in = {i_din_re, i_din_im, i_pkg_type, i_cell_idx,
                      i_slot_idx, i_symb_idx, i_agc};

    // --------------------
    // Strobes and pointer
    // --------------------

    // Oldest entry read out and overwritten by the new one
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ptr    <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                strb_mem[i] <= '0;
            end
        end else begin
            strb_mem[ptr] <= {i_sel, i_sop, i_eop, i_vld};
            ptr           <= (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
        end
    end

    // --------------------
    // Payload
    // --------------------
    always_ff @(posedge clk) begin
        data_mem[ptr] <= data_in;
    end

    // Slot under the pointer holds the entry written DEPTH cycles ago
    assign strb_q = strb_mem[ptr];
    assign data_q = data_mem[ptr];

    assign {o_sel, o_sop, o_eop, o_vld} = strb_q;
    assign {o_din_re, o_din_im, o_pkg_type, o_cell_idx,
            o_slot_idx, o_symb_idx, o_agc} = data_q;

endmodule

// File: design/mantissa_shift.sv
`timescale 1ns/1ns

module mantissa_shift
    import bfp_sample_pkg::*;
#(
    parameter int NUM_CH = 4,
    parameter int IW     = IW_MAX,
    parameter int OW     = OW_MAX
) (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_sop,
    input  sample_t [NUM_CH-1:0]    i_din_re,
    input  sample_t [NUM_CH-1:0]    i_din_im,
    input  shift_t                  i_shift,
    output mant_t   [NUM_CH-1:0]    o_dout_re,
    output mant_t   [NUM_CH-1:0]    o_dout_im,
    output shift_t                  o_shift
);

    shift_t               cur_shift;
    logic signed [IW-1:0] sh_re [NUM_CH];
    logic signed [IW-1:0] sh_im [NUM_CH];

    // New shift applies from the first sample of the symbol
    always_comb begin
        cur_shift = i_sop ? i_shift : o_shift;
        for (int c = 0; c < NUM_CH; c++) begin
            sh_re[c] = $signed(i_din_re[c]) >>> cur_shift;
            sh_im[c] = $signed(i_din_im[c]) >>> cur_shift;
        end
    end

    // --------------------
    // Output registers
    // --------------------

    // o_shift doubles as the held shift for the symbol
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_shift <= '0;
        end else begin
            o_shift <= cur_shift;
        end
    end

    // Truncate to the low OW bits
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            o_dout_re[c] <= mant_t'(sh_re[c][OW-1:0]);
            o_dout_im[c] <= mant_t'(sh_im[c][OW-1:0]);
        end
    end

endmodule

// File: design/beam_power_store.sv
`timescale 1ns/1ns

module beam_power_store
    import bfp_header_pkg::*;
#(
    parameter int NUM_CH = 4,
    parameter int DEPTH  = 19
) (
    input  logic                      clk,
    input  logic                      i_reset,
    input  logic                      i_rbg_load,
    input  beam_pwr_t [NUM_CH-1:0]    i_beam_pwr,
    output logic                      o_rbg_load,
    output beam_pwr_t                 o_beam_pwr,
    output rbg_idx_t                  o_rbg_idx
);

    beam_pwr_t [NUM_CH-1:0] pwr_vec;
    logic [DEPTH-1:0]       load_sr;
    logic                   load_dly;
    rbg_idx_t               rd_idx;

    // Latest vector, overwritten on every load
    always_ff @(posedge clk) begin
        if (i_rbg_load) begin
            pwr_vec <= i_beam_pwr;
        end
    end

    // --------------------
    // Load pulse delay
    // --------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            load_sr <= '0;
        end else begin
            load_sr <= {load_sr[DEPTH-2:0], i_rbg_load};
        end
    end

    assign load_dly = load_sr[DEPTH-1];

    // --------------------
    // Readout
    // --------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rbg_load <= 1'b0;
            o_rbg_idx  <= '0;
            rd_idx     <= '0;
        end else begin
            o_rbg_load <= load_dly;
            if (load_dly) begin
                o_rbg_idx <= rd_idx;
                // Index wraps at the channel count
                rd_idx    <= (rd_idx == rbg_idx_t'(NUM_CH - 1)) ? '0 : rd_idx + rbg_idx_t'(1);
            end
        end
    end

    // Payload held between pulses
    always_ff @(posedge clk) begin
        if (load_dly) begin
            o_beam_pwr <= pwr_vec[rd_idx];
        end
    end

endmodule

// File: design/bfp_compressor.sv
`timescale 1ns/1ns

module bfp_compressor
    import bfp_sample_pkg::*;
    import bfp_header_pkg::*;
#(
    parameter int NUM_CH  = 4,
    parameter int IW      = IW_MAX,
    parameter int OW      = OW_MAX,
    parameter int SYM_LEN = 16
) (
    input  logic                      clk,
    input  logic                      i_reset,
    input  logic                      i_sel,
    input  logic                      i_sop,
    input  logic                      i_eop,
    input  logic                      i_vld,
    input  sample_t   [NUM_CH-1:0]    i_din_re,
    input  sample_t   [NUM_CH-1:0]    i_din_im,
    input  logic                      i_rbg_load,
    input  beam_pwr_t [NUM_CH-1:0]    i_beam_pwr,
    input  info_t                     i_info,
    input  agc_t      [NUM_CH-1:0]    i_agc,
    output logic                      o_sel,
    output logic                      o_sop,
    output logic                      o_eop,
    output logic                      o_vld,
    output mant_t     [NUM_CH-1:0]    o_dout_re,
    output mant_t     [NUM_CH-1:0]    o_dout_im,
    output shift_t                    o_shift,
    output logic                      o_rbg_load,
    output beam_pwr_t                 o_beam_pwr,
    output rbg_idx_t                  o_rbg_idx,
    output pkg_type_t                 o_pkg_type,
    output cell_idx_t                 o_cell_idx,
    output slot_idx_t                 o_slot_idx,
    output symb_idx_t                 o_symb_idx,
    output agc_t      [NUM_CH-1:0]    o_agc
);

    // Input to output latency for every stream
    localparam int LAT = SYM_LEN + 4;

    peak_t [NUM_CH-1:0]   peak;
    logic                 peak_vld;
    shift_t               shift;
    logic                 dl_sel;
    logic                 dl_sop;
    logic                 dl_eop;
    logic                 dl_vld;
    sample_t [NUM_CH-1:0] dl_din_re;
    sample_t [NUM_CH-1:0] dl_din_im;
    pkg_type_t            dl_pkg_type;
    cell_idx_t            dl_cell_idx;
    slot_idx_t            dl_slot_idx;
    symb_idx_t            dl_symb_idx;
    agc_t [NUM_CH-1:0]    dl_agc;
    pkg_type_t            pkg_type;
    cell_idx_t            cell_idx;
    slot_idx_t            slot_idx;
    symb_idx_t            symb_idx;

    // Header fields from the info word
    assign pkg_type = i_info[PKG_TYPE_LSB +: $bits(pkg_type_t)];
    assign cell_idx = i_info[CELL_IDX_BIT];
    assign slot_idx = i_info[SLOT_IDX_LSB +: $bits(slot_idx_t)];
    assign symb_idx = i_info[SYMB_IDX_LSB +: $bits(symb_idx_t)];

    // --------------------
    // Exponent path
    // --------------------
    block_peak_search #(.NUM_CH(NUM_CH), .IW(IW)) u_peak (
        .clk(clk), .i_reset(i_reset),
        .i_sop(i_sop), .i_eop(i_eop), .i_vld(i_vld),
        .i_din_re(i_din_re), .i_din_im(i_din_im),
        .o_peak(peak), .o_peak_vld(peak_vld)
    );

    // Strobe not needed downstream; the held shift is sampled at delayed sop
    exponent_select #(.NUM_CH(NUM_CH), .IW(IW), .OW(OW)) u_expo (
        .clk(clk), .i_reset(i_reset),
        .i_peak(peak), .i_peak_vld(peak_vld),
        .o_shift(shift), .o_shift_vld()
    );

    // --------------------
    // Data path
    // --------------------
    symbol_delay_line #(.NUM_CH(NUM_CH), .IW(IW), .DEPTH(LAT - 1)) u_delay (
        .clk(clk), .i_reset(i_reset),
        .i_sel(i_sel), .i_sop(i_sop), .i_eop(i_eop), .i_vld(i_vld),
        .i_din_re(i_din_re), .i_din_im(i_din_im),
        .i_pkg_type(pkg_type), .i_cell_idx(cell_idx),
        .i_slot_idx(slot_idx), .i_symb_idx(symb_idx), .i_agc(i_agc),
        .o_sel(dl_sel), .o_sop(dl_sop), .o_eop(dl_eop), .o_vld(dl_vld),
        .o_din_re(dl_din_re), .o_din_im(dl_din_im),
        .o_pkg_type(dl_pkg_type), .o_cell_idx(dl_cell_idx),
        .o_slot_idx(dl_slot_idx), .o_symb_idx(dl_symb_idx), .o_agc(dl_agc)
    );

    mantissa_shift #(.NUM_CH(NUM_CH), .IW(IW), .OW(OW)) u_shift (
        .clk(clk), .i_reset(i_reset), .i_sop(dl_sop),
        .i_din_re(dl_din_re), .i_din_im(dl_din_im), .i_shift(shift),
        .o_dout_re(o_dout_re), .o_dout_im(o_dout_im), .o_shift(o_shift)
    );

    // Side channels matched to the mantissa register stage
    always_ff @(posedge clk) begin
        if (i_reset) begin
            {o_sel, o_sop, o_eop, o_vld} <= '0;
        end else begin
            {o_sel, o_sop, o_eop, o_vld} <= {dl_sel, dl_sop, dl_eop, dl_vld};
        end
    end

    always_ff @(posedge clk) begin
        o_pkg_type <= dl_pkg_type;
        o_cell_idx <= dl_cell_idx;
        o_slot_idx <= dl_slot_idx;
        o_symb_idx <= dl_symb_idx;
        o_agc      <= dl_agc;
    end

    // --------------------
    // Beam power
    // --------------------
    beam_power_store #(.NUM_CH(NUM_CH), .DEPTH(LAT - 1)) u_beam (
        .clk(clk), .i_reset(i_reset),
        .i_rbg_load(i_rbg_load), .i_beam_pwr(i_beam_pwr),
        .o_rbg_load(o_rbg_load), .o_beam_pwr(o_beam_pwr), .o_rbg_idx(o_rbg_idx)
    );

endmodule

// File: bench/bfp_compressor_tb.sv
`timescale 1ns/1ns

module bfp_compressor_tb;

    localparam int NUM_CH    = 4;
    localparam int IW        = 24;
    localparam int OW        = 12;
    localparam int SYM_LEN   = 16;
    localparam int LAT       = SYM_LEN + 4;
    localparam int CLK_PER   = 4;
    localparam int NUM_TESTS = 8;
    localparam int HIST_LEN  = 2048;
    localparam int WD_CYCLES = NUM_TESTS * (SYM_LEN + LAT + 8) + 100;

    // --------------------
    // Test table
    // --------------------

    // Magnitude bits per sample where zero gives an all-zero symbol
    localparam int TBL_BITS  [NUM_TESTS] = '{23, 5, 12, 0, 11, 20, 16, 1};
    localparam int TBL_SHIFT [NUM_TESTS] = '{12, 0, 1, 0, 0, 9, 5, 0};
    localparam int TBL_SEL   [NUM_TESTS] = '{1, 0, 1, 0, 1, 0, 1, 1};
    // Idle cycles after the symbol
    localparam int TBL_GAP   [NUM_TESTS] = '{0, 4, 0, 4, 0, 0, 6, 6};
    localparam int TBL_LOAD  [NUM_TESTS] = '{1, 0, 1, 0, 1, 0, 1, 1};
    localparam int TBL_PKG   [NUM_TESTS] = '{3, 12, 5, 0, 9, 15, 6, 1};
    localparam int TBL_CELL  [NUM_TESTS] = '{0, 1, 1, 0, 1, 0, 0, 1};
    localparam int TBL_SLOT  [NUM_TESTS] = '{0, 17, 42, 99, 127, 64, 3, 85};
    localparam int TBL_SYMB  [NUM_TESTS] = '{0, 1, 2, 3, 13, 7, 14, 15};
    localparam int TBL_AGC   [NUM_TESTS] = '{16, 200, 37, 255, 90, 1, 128, 64};
    localparam logic [31:0] TBL_BEAM [NUM_TESTS] = '{
        32'h1000_0100, 32'h2000_0200, 32'h3000_0300, 32'h4000_0400,
        32'h5000_0500, 32'h6000_0600, 32'h7000_0700, 32'h8000_0800
    };

    logic                     clk = 1'b0;
    logic                     i_reset;
    logic                     i_sel;
    logic                     i_sop;
    logic                     i_eop;
    logic                     i_vld;
    logic [NUM_CH-1:0][IW-1:0] i_din_re;
    logic [NUM_CH-1:0][IW-1:0] i_din_im;
    logic                     i_rbg_load;
    logic [NUM_CH-1:0][31:0]  i_beam_pwr;
    logic [63:0]              i_info;
    logic [NUM_CH-1:0][7:0]   i_agc;
    logic                     o_sel;
    logic                     o_sop;
    logic                     o_eop;
    logic                     o_vld;
    logic [NUM_CH-1:0][OW-1:0] o_dout_re;
    logic [NUM_CH-1:0][OW-1:0] o_dout_im;
    logic [3:0]               o_shift;
    logic                     o_rbg_load;
    logic [31:0]              o_beam_pwr;
    logic [3:0]               o_rbg_idx;
    logic [3:0]               o_pkg_type;
    logic                     o_cell_idx;
    logic [6:0]               o_slot_idx;
    logic [3:0]               o_symb_idx;
    logic [NUM_CH-1:0][7:0]   o_agc;

    logic [31:0] lfsr = 32'ha723;
    int          cyc = 0;
    int          err_count = 0;
    int          samples_seen = 0;
    int          beam_seen = 0;
    int          load_count = 0;
    int          test_errs [NUM_TESTS];
    // {load, sel, sop, eop, vld} as driven in each cycle
    logic [4:0]  hist [HIST_LEN];

    int                   exp_cyc_q [$];
    int                   exp_test_q [$];
    int                   exp_shift_q [$];
    logic [NUM_CH*OW-1:0] exp_re_q [$];
    logic [NUM_CH*OW-1:0] exp_im_q [$];
    logic [15:0]          exp_hdr_q [$];
    logic [NUM_CH*8-1:0]  exp_agc_q [$];
    int                   beam_cyc_q [$];
    int                   beam_idx_q [$];
    logic [31:0]          beam_val_q [$];

    bfp_compressor #(
        .NUM_CH(NUM_CH), .IW(IW), .OW(OW), .SYM_LEN(SYM_LEN)
    ) bfp_compressor_inst (
        .clk(clk), .i_reset(i_reset),
        .i_sel(i_sel), .i_sop(i_sop), .i_eop(i_eop), .i_vld(i_vld),
        .i_din_re(i_din_re), .i_din_im(i_din_im),
        .i_rbg_load(i_rbg_load), .i_beam_pwr(i_beam_pwr),
        .i_info(i_info), .i_agc(i_agc),
        .o_sel(o_sel), .o_sop(o_sop), .o_eop(o_eop), .o_vld(o_vld),
        .o_dout_re(o_dout_re), .o_dout_im(o_dout_im), .o_shift(o_shift),
        .o_rbg_load(o_rbg_load), .o_beam_pwr(o_beam_pwr), .o_rbg_idx(o_rbg_idx),
        .o_pkg_type(o_pkg_type), .o_cell_idx(o_cell_idx),
        .o_slot_idx(o_slot_idx), .o_symb_idx(o_symb_idx), .o_agc(o_agc)
    );

    always #(CLK_PER / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // --------------------
    // Stimulus helpers
    // --------------------

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int magnitude(input int x);
        return (x < 0) ? -x : x;
    endfunction

    // Smallest shift that leaves the peak below 2**(OW-1)
    function automatic int shift_for_peak(input int peak);
        for (int s = 0; s < IW - OW; s++) begin
            if ((peak >> s) < (1 << (OW - 1))) begin
                return s;
            end
        end
        return IW - OW;
    endfunction

    function automatic logic [4:0] strobes_at(input int k);
        if (k < 0 || k >= HIST_LEN) begin
            return '0;
        end
        return hist[k];
    endfunction

    task automatic drive_idle();
        i_sel      = 1'b0;
        i_sop      = 1'b0;
        i_eop      = 1'b0;
        i_vld      = 1'b0;
        i_rbg_load = 1'b0;
        i_din_re   = '0;
        i_din_im   = '0;
        i_info     = '0;
        i_agc      = '0;
        hist[cyc]  = '0;
    endtask

    task automatic report_mismatch(input int t, input string name,
                                   input logic [63:0] want, input logic [63:0] got);
        $display("FAILED t=%0t %s expected %h actual %h", $time, name, want, got);
        err_count++;
        if (t >= 0) begin
            test_errs[t]++;
        end
    endtask

    // One symbol from table entry t with its model results queued before driving
    task automatic run_symbol(input int t);
        int                      re_s [SYM_LEN][NUM_CH];
        int                      im_s [SYM_LEN][NUM_CH];
        int                      mask;
        int                      mag;
        int                      peak;
        int                      s;
        logic [63:0]             info_w;
        logic [NUM_CH-1:0][7:0]  agc_w;
        logic [NUM_CH-1:0][31:0] beam_w;
        logic [NUM_CH*OW-1:0]    mre;
        logic [NUM_CH*OW-1:0]    mim;

        mask = (1 << TBL_BITS[t]) - 1;
        peak = 0;
        for (int n = 0; n < SYM_LEN; n++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                mag = int'(rand_bits(IW)) & mask;
                // Top bit forced once so the peak lands where the table says
                if (n == 0 && c == 0 && TBL_BITS[t] > 0) begin
                    mag = mag | (1 << (TBL_BITS[t] - 1));
                end
                re_s[n][c] = lfsr_bit() ? -mag : mag;
                mag = int'(rand_bits(IW)) & mask;
                im_s[n][c] = lfsr_bit() ? -mag : mag;
                peak = peak | magnitude(re_s[n][c]) | magnitude(im_s[n][c]);
            end
        end
        s = shift_for_peak(peak);
        if (s != TBL_SHIFT[t]) begin
            $display("Test %0d stimulus gives shift %0d but the table expects %0d",
                     t, s, TBL_SHIFT[t]);
            err_count++;
            test_errs[t]++;
        end

        info_w        = rand_bits(64);
        info_w[39:36] = 4'(TBL_PKG[t]);
        info_w[19]    = 1'(TBL_CELL[t]);
        info_w[18:12] = 7'(TBL_SLOT[t]);
        info_w[11:8]  = 4'(TBL_SYMB[t]);
        for (int c = 0; c < NUM_CH; c++) begin
            agc_w[c]  = 8'(TBL_AGC[t] + 17 * c);
            beam_w[c] = TBL_BEAM[t] + 32'(c);
        end

        for (int n = 0; n < SYM_LEN; n++) begin
            @(negedge clk);
            for (int c = 0; c < NUM_CH; c++) begin
                i_din_re[c]       = IW'(re_s[n][c]);
                i_din_im[c]       = IW'(im_s[n][c]);
                mre[c*OW +: OW]   = OW'(re_s[n][c] >>> s);
                mim[c*OW +: OW]   = OW'(im_s[n][c] >>> s);
            end
            exp_cyc_q.push_back(cyc + LAT);
            exp_test_q.push_back(t);
            exp_shift_q.push_back(s);
            exp_re_q.push_back(mre);
            exp_im_q.push_back(mim);
            exp_hdr_q.push_back({info_w[39:36], info_w[19], info_w[18:12], info_w[11:8]});
            exp_agc_q.push_back(agc_w);
            i_sel      = 1'(TBL_SEL[t]);
            i_sop      = (n == 0);
            i_eop      = (n == SYM_LEN - 1);
            i_vld      = 1'b1;
            i_info     = info_w;
            i_agc      = agc_w;
            i_rbg_load = (n == 0) && (TBL_LOAD[t] != 0);
            if (i_rbg_load) begin
                i_beam_pwr = beam_w;
                beam_cyc_q.push_back(cyc + LAT);
                beam_idx_q.push_back(load_count % NUM_CH);
                beam_val_q.push_back(beam_w[load_count % NUM_CH]);
                load_count++;
            end
            hist[cyc] = {i_rbg_load, i_sel, i_sop, i_eop, i_vld};
        end
        repeat (TBL_GAP[t]) begin
            @(negedge clk);
            drive_idle();
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------
    task automatic check_outputs();
        logic [4:0]           want_d;
        logic [15:0]          hdr;
        logic [NUM_CH*OW-1:0] want_re;
        logic [NUM_CH*OW-1:0] want_im;
        logic [NUM_CH*8-1:0]  want_agc;
        int                   t;
        int                   want_shift;
        int                   want_cyc;

        want_d = strobes_at(cyc - LAT);
        if ({o_sel, o_sop, o_eop, o_vld} !== want_d[3:0]) begin
            report_mismatch(-1, "{o_sel,o_sop,o_eop,o_vld}", want_d[3:0],
                            {o_sel, o_sop, o_eop, o_vld});
        end
        if (o_rbg_load !== want_d[4]) begin
            report_mismatch(-1, "o_rbg_load", want_d[4], o_rbg_load);
        end

        if (o_vld === 1'b1 && exp_cyc_q.size() == 0) begin
            $display("Output sample at %0t arrived with no symbol pending", $time);
            err_count++;
        end else if (o_vld === 1'b1) begin
            want_cyc   = exp_cyc_q.pop_front();
            t          = exp_test_q.pop_front();
            want_shift = exp_shift_q.pop_front();
            want_re    = exp_re_q.pop_front();
            want_im    = exp_im_q.pop_front();
            hdr        = exp_hdr_q.pop_front();
            want_agc   = exp_agc_q.pop_front();
            samples_seen++;
            if (cyc != want_cyc) begin
                report_mismatch(t, "o_vld cycle", want_cyc, cyc);
            end
            if (o_shift !== 4'(want_shift)) begin
                report_mismatch(t, "o_shift", want_shift, o_shift);
            end
            for (int c = 0; c < NUM_CH; c++) begin
                if (o_dout_re[c] !== want_re[c*OW +: OW]) begin
                    report_mismatch(t, $sformatf("o_dout_re[%0d]", c),
                                    want_re[c*OW +: OW], o_dout_re[c]);
                end
                if (o_dout_im[c] !== want_im[c*OW +: OW]) begin
                    report_mismatch(t, $sformatf("o_dout_im[%0d]", c),
                                    want_im[c*OW +: OW], o_dout_im[c]);
                end
            end
            if ({o_pkg_type, o_cell_idx, o_slot_idx, o_symb_idx} !== hdr) begin
                report_mismatch(t, "{o_pkg_type,o_cell_idx,o_slot_idx,o_symb_idx}", hdr,
                                {o_pkg_type, o_cell_idx, o_slot_idx, o_symb_idx});
            end
            if (o_agc !== want_agc) begin
                report_mismatch(t, "o_agc", want_agc, o_agc);
            end
            if (o_eop === 1'b1) begin
                $display("test %0d done: %0d magnitude bits, shift %0d, %0d errors",
                         t, TBL_BITS[t], want_shift, test_errs[t]);
            end
        end

        if (o_rbg_load === 1'b1 && beam_cyc_q.size() == 0) begin
            $display("Beam power read at %0t arrived with no load pending", $time);
            err_count++;
        end else if (o_rbg_load === 1'b1) begin
            want_cyc = beam_cyc_q.pop_front();
            beam_seen++;
            if (cyc != want_cyc) begin
                report_mismatch(-1, "o_rbg_load cycle", want_cyc, cyc);
            end
            if (o_rbg_idx !== 4'(beam_idx_q[0])) begin
                report_mismatch(-1, "o_rbg_idx", beam_idx_q[0], o_rbg_idx);
            end
            if (o_beam_pwr !== beam_val_q[0]) begin
                report_mismatch(-1, "o_beam_pwr", beam_val_q[0], o_beam_pwr);
            end
            beam_idx_q.pop_front();
            beam_val_q.pop_front();
        end
    endtask

    always @(negedge clk) begin
        check_outputs();
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        for (int k = 0; k < HIST_LEN; k++) begin
            hist[k] = '0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errs[t] = 0;
        end
        i_reset    = 1'b1;
        i_beam_pwr = '0;
        drive_idle();
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_symbol(t);
        end
        @(negedge clk);
        drive_idle();

        while (exp_cyc_q.size() > 0 || beam_cyc_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("%0d tests, %0d samples, %0d beam reads checked, %0d errors",
                 NUM_TESTS, samples_seen, beam_seen, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WD_CYCLES * CLK_PER);
        $display("Simulation did not finish within %0d cycles", WD_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: bfp_compressor.f
design/bfp_sample_pkg.sv
design/bfp_header_pkg.sv
design/block_peak_search.sv
design/exponent_select.sv
design/symbol_delay_line.sv
design/mantissa_shift.sv
design/beam_power_store.sv
design/bfp_compressor.sv
bench/bfp_compressor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench and RTL with Verilator, run, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module bfp_compressor_tb \
    -f bfp_compressor.f --Mdir obj_dir -o bfp_sim || exit 1
out=$(./obj_dir/bfp_sim)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
